// ==== hdl/pmp_defs.svh ====
`ifndef PMP_DEFS_SVH
`define PMP_DEFS_SVH

// --------------------------------------------------
// PMP build configuration
// --------------------------------------------------

// Number of implemented regions, 1 to 16
`define PMP_NUM_REGIONS 8

// Granule size is 2^(PMP_GRANULARITY+2) bytes
// 0 gives 4-byte granules
`define PMP_GRANULARITY 0

// Physical address width
`define PMP_PADDR_W 34

// CSR data width
// An address register holds physical bits 33 down to 2
`define PMP_CSR_W 32

`endif

// ==== hdl/pmp_pkg.sv ====
`default_nettype none

package pmp_pkg;

  // Region match mode, as stored in cfg bits 4:3
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // Access type of a request
  typedef enum logic [1:0] {
    PMP_ACC_READ  = 2'b00,
    PMP_ACC_WRITE = 2'b01,
    PMP_ACC_EXEC  = 2'b10
  } pmp_acc_e;

  // Privilege levels, RISC-V encoding
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // CSR target of a write or readback
  typedef enum logic [1:0] {
    PMP_CSR_CFG     = 2'b00,
    PMP_CSR_ADDR    = 2'b01,
    PMP_CSR_MSECCFG = 2'b10
  } pmp_csr_sel_e;

  // Bit positions inside a configuration byte
  localparam int unsigned PMP_CFG_R_BIT    = 0;
  localparam int unsigned PMP_CFG_W_BIT    = 1;
  localparam int unsigned PMP_CFG_X_BIT    = 2;
  localparam int unsigned PMP_CFG_MODE_LSB = 3;
  localparam int unsigned PMP_CFG_L_BIT    = 7;

  // Bit positions inside the security configuration register
  localparam int unsigned PMP_MSEC_MML_BIT  = 0;
  localparam int unsigned PMP_MSEC_MMWP_BIT = 1;
  localparam int unsigned PMP_MSEC_RLB_BIT  = 2;

endpackage

`default_nettype wire

// ==== hdl/pmp_csr.sv ====
`default_nettype none

`include "pmp_defs.svh"

module pmp_csr import pmp_pkg::*; (
  input  logic                                          clk,
  input  logic                                          rst_n_i,
  // CSR strobe port
  input  logic                                          csr_we_i,
  input  pmp_csr_sel_e                                  csr_sel_i,
  input  logic [3:0]                                    csr_idx_i,
  input  logic [`PMP_CSR_W-1:0]                         csr_wdata_i,
  output logic [`PMP_CSR_W-1:0]                         csr_rdata_o,
  // Per-region configuration towards the checker
  output logic [`PMP_NUM_REGIONS-1:0]                   cfg_read_o,
  output logic [`PMP_NUM_REGIONS-1:0]                   cfg_write_o,
  output logic [`PMP_NUM_REGIONS-1:0]                   cfg_exec_o,
  output logic [`PMP_NUM_REGIONS-1:0]                   cfg_lock_o,
  output pmp_mode_e [`PMP_NUM_REGIONS-1:0]              cfg_mode_o,
  output logic [`PMP_NUM_REGIONS-1:0][`PMP_PADDR_W-1:0] region_addr_o,
  // Security configuration
  output logic                                          mml_o,
  output logic                                          mmwp_o,
  output logic                                          rlb_o
);

  localparam int unsigned NR = `PMP_NUM_REGIONS;

  // Region state
  logic [NR-1:0]                 read_q;
  logic [NR-1:0]                 write_q;
  logic [NR-1:0]                 exec_q;
  logic [NR-1:0]                 lock_q;
  pmp_mode_e [NR-1:0]            mode_q;
  logic [NR-1:0][`PMP_CSR_W-1:0] addr_q;
  // Security configuration state
  logic                          mml_q;
  logic                          mmwp_q;
  logic                          rlb_q;
  // Write decode
  logic [NR-1:0]                 idx_hit;
  logic [NR-1:0]                 lock_eff;
  logic [NR-1:0]                 next_tor_lock;
  logic [NR-1:0]                 cfg_we;
  logic [NR-1:0]                 addr_we;
  logic                          msec_we;

  // --------------------------------------------------
  // Region registers
  // --------------------------------------------------
  for (genvar r = 0; r < NR; r++) begin : g_region
    assign idx_hit[r]  = csr_we_i && (csr_idx_i == 4'(r));
    // RLB lifts every lock
    assign lock_eff[r] = lock_q[r] && !rlb_q;

    // Locked TOR entry above also protects this address
    if (r < NR - 1) begin : g_next
      assign next_tor_lock[r] = lock_eff[r+1] && (mode_q[r+1] == PMP_MODE_TOR);
    end else begin : g_last
      assign next_tor_lock[r] = 1'b0;
    end

    assign cfg_we[r]  = idx_hit[r] && (csr_sel_i == PMP_CSR_CFG) && !lock_eff[r];
    assign addr_we[r] = idx_hit[r] && (csr_sel_i == PMP_CSR_ADDR) &&
                        !lock_eff[r] && !next_tor_lock[r];

    always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
        read_q[r]  <= 1'b0;
        write_q[r] <= 1'b0;
        exec_q[r]  <= 1'b0;
        lock_q[r]  <= 1'b0;
        mode_q[r]  <= PMP_MODE_OFF;
        addr_q[r]  <= '0;
      end else begin
        if (cfg_we[r]) begin
          read_q[r]  <= csr_wdata_i[PMP_CFG_R_BIT];
          write_q[r] <= csr_wdata_i[PMP_CFG_W_BIT];
          exec_q[r]  <= csr_wdata_i[PMP_CFG_X_BIT];
          mode_q[r]  <= pmp_mode_e'(csr_wdata_i[PMP_CFG_MODE_LSB +: 2]);
          lock_q[r]  <= csr_wdata_i[PMP_CFG_L_BIT];
        end
        if (addr_we[r]) begin
          addr_q[r] <= csr_wdata_i;
        end
      end
    end

    // Register holds physical bits 33:2
    assign region_addr_o[r] = {addr_q[r], 2'b00};
  end

  // --------------------------------------------------
  // Security configuration
  // --------------------------------------------------
  assign msec_we = csr_we_i && (csr_sel_i == PMP_CSR_MSECCFG);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mml_q  <= 1'b0;
      mmwp_q <= 1'b0;
      rlb_q  <= 1'b0;
    end else if (msec_we) begin
      // MML and MMWP are set-only until reset
      mml_q  <= mml_q  || csr_wdata_i[PMP_MSEC_MML_BIT];
      mmwp_q <= mmwp_q || csr_wdata_i[PMP_MSEC_MMWP_BIT];
      // RLB sets only with no entry locked, clears at any time
      rlb_q  <= csr_wdata_i[PMP_MSEC_RLB_BIT] && (rlb_q || !(|lock_q));
    end
  end

  // Combinational readback, zero for unimplemented index
  always_comb begin
    csr_rdata_o = '0;
    case (csr_sel_i)
      PMP_CSR_CFG: begin
        for (int r = 0; r < NR; r++) begin
          if (csr_idx_i == 4'(r)) begin
            csr_rdata_o[PMP_CFG_R_BIT]           = read_q[r];
            csr_rdata_o[PMP_CFG_W_BIT]           = write_q[r];
            csr_rdata_o[PMP_CFG_X_BIT]           = exec_q[r];
            csr_rdata_o[PMP_CFG_MODE_LSB +: 2]   = mode_q[r];
            csr_rdata_o[PMP_CFG_L_BIT]           = lock_q[r];
          end
        end
      end
      PMP_CSR_ADDR: begin
        for (int r = 0; r < NR; r++) begin
          if (csr_idx_i == 4'(r)) csr_rdata_o = addr_q[r];
        end
      end
      PMP_CSR_MSECCFG: begin
        csr_rdata_o[PMP_MSEC_MML_BIT]  = mml_q;
        csr_rdata_o[PMP_MSEC_MMWP_BIT] = mmwp_q;
        csr_rdata_o[PMP_MSEC_RLB_BIT]  = rlb_q;
      end
      default: csr_rdata_o = '0;
    endcase
  end

  assign cfg_read_o  = read_q;
  assign cfg_write_o = write_q;
  assign cfg_exec_o  = exec_q;
  assign cfg_lock_o  = lock_q;
  assign cfg_mode_o  = mode_q;
  assign mml_o       = mml_q;
  assign mmwp_o      = mmwp_q;
  assign rlb_o       = rlb_q;

  // Once set, the policy bits hold until reset
  a_mmwp_sticky: assert property (@(posedge clk) disable iff (!rst_n_i) mmwp_q |=> mmwp_q);
  a_mml_sticky:  assert property (@(posedge clk) disable iff (!rst_n_i) mml_q |=> mml_q);

endmodule

`default_nettype wire

// ==== hdl/pmp_checker.sv ====
`default_nettype none

`include "pmp_defs.svh"

module pmp_checker import pmp_pkg::*; (
  // Region configuration
  input  logic [`PMP_NUM_REGIONS-1:0]                   cfg_read_i,
  input  logic [`PMP_NUM_REGIONS-1:0]                   cfg_write_i,
  input  logic [`PMP_NUM_REGIONS-1:0]                   cfg_exec_i,
  input  logic [`PMP_NUM_REGIONS-1:0]                   cfg_lock_i,
  input  pmp_mode_e [`PMP_NUM_REGIONS-1:0]              cfg_mode_i,
  input  logic [`PMP_NUM_REGIONS-1:0][`PMP_PADDR_W-1:0] region_addr_i,
  input  logic                                          mml_i,
  input  logic                                          mmwp_i,
  // Current request
  input  logic [`PMP_PADDR_W-1:0]                       req_addr_i,
  input  pmp_acc_e                                      req_type_i,
  input  priv_lvl_e                                     req_priv_i,
  output logic                                          access_fault_o
);

  localparam int NR = `PMP_NUM_REGIONS;
  localparam int G  = `PMP_GRANULARITY;
  localparam int AW = `PMP_PADDR_W;

  logic [NR-1:0][AW-1:0]   start_addr;
  logic [NR-1:0][AW-1:G+2] napot_mask;
  logic [NR-1:0]           match_eq;
  logic [NR-1:0]           match_gt;
  logic [NR-1:0]           match_lt;
  logic [NR-1:0]           match_all;
  logic [NR-1:0]           basic_ok;
  logic [NR-1:0]           mml_ok;
  logic                    is_m;

  assign is_m = (req_priv_i == PRIV_LVL_M);

  // --------------------------------------------------
  // Per-region matching and permissions
  // --------------------------------------------------
  for (genvar r = 0; r < NR; r++) begin : g_region

    // TOR lower bound comes from the entry below, zero for entry 0
    if (r == 0) begin : g_first
      assign start_addr[r] = (cfg_mode_i[r] == PMP_MODE_TOR) ? '0 : region_addr_i[r];
    end else begin : g_other
      assign start_addr[r] = (cfg_mode_i[r] == PMP_MODE_TOR) ? region_addr_i[r-1] :
                             region_addr_i[r];
    end

    // NAPOT mask, a bit is compared only above the trailing ones
    always_comb begin : p_mask
      logic ones;
      ones = 1'b1;
      for (int b = G + 2; b < AW; b++) begin
        if (b == 2) begin
          // Smallest NAPOT region is 8 bytes
          napot_mask[r][b] = (cfg_mode_i[r] != PMP_MODE_NAPOT);
        end else begin
          ones = ones && region_addr_i[r][b-1];
          napot_mask[r][b] = (cfg_mode_i[r] != PMP_MODE_NAPOT) || !ones;
        end
      end
    end

    // Comparators at granule resolution
    assign match_eq[r] = (req_addr_i[AW-1:G+2] & napot_mask[r]) ==
                         (start_addr[r][AW-1:G+2] & napot_mask[r]);
    assign match_gt[r] = req_addr_i[AW-1:G+2] > start_addr[r][AW-1:G+2];
    assign match_lt[r] = req_addr_i[AW-1:G+2] < region_addr_i[r][AW-1:G+2];

    always_comb begin
      case (cfg_mode_i[r])
        PMP_MODE_TOR:   match_all[r] = (match_eq[r] || match_gt[r]) && match_lt[r];
        PMP_MODE_NA4:   match_all[r] = match_eq[r];
        PMP_MODE_NAPOT: match_all[r] = match_eq[r];
        default:        match_all[r] = 1'b0;
      endcase
    end

    // R, W, X against the access type
    assign basic_ok[r] = ((req_type_i == PMP_ACC_READ)  && cfg_read_i[r])  ||
                         ((req_type_i == PMP_ACC_WRITE) && cfg_write_i[r]) ||
                         ((req_type_i == PMP_ACC_EXEC)  && cfg_exec_i[r]);

    // Permission under MML
    always_comb begin
      if (!cfg_read_i[r] && cfg_write_i[r]) begin
        // Shared regions, selected by L and X
        case ({cfg_lock_i[r], cfg_exec_i[r]})
          // M read/write, S/U read
          2'b00: mml_ok[r] = (req_type_i == PMP_ACC_READ) ||
                             ((req_type_i == PMP_ACC_WRITE) && is_m);
          // Read/write for all
          2'b01: mml_ok[r] = (req_type_i == PMP_ACC_READ) ||
                             (req_type_i == PMP_ACC_WRITE);
          // Execute for all
          2'b10: mml_ok[r] = (req_type_i == PMP_ACC_EXEC);
          // M read/execute, S/U execute
          default: mml_ok[r] = (req_type_i == PMP_ACC_EXEC) ||
                               ((req_type_i == PMP_ACC_READ) && is_m);
        endcase
      end else if (cfg_read_i[r] && cfg_write_i[r] && cfg_exec_i[r] && cfg_lock_i[r]) begin
        // Shared read-only for every mode
        mml_ok[r] = (req_type_i == PMP_ACC_READ);
      end else begin
        // Locked entries serve M only, unlocked ones S/U only
        mml_ok[r] = basic_ok[r] && (is_m ? cfg_lock_i[r] : !cfg_lock_i[r]);
      end
    end
  end

  // --------------------------------------------------
  // Fault decision
  // --------------------------------------------------
  always_comb begin
    // Unmatched: M passes unless MMWP, S/U always fault
    access_fault_o = mmwp_i || !is_m;
    // Walk downward so region 0 has the final say
    for (int r = NR - 1; r >= 0; r--) begin
      if (match_all[r]) begin
        if (mml_i) begin
          access_fault_o = !mml_ok[r];
        end else if (is_m) begin
          // M mode is bound only by locked entries
          access_fault_o = cfg_lock_i[r] && !basic_ok[r];
        end else begin
          access_fault_o = !basic_ok[r];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/pmp_access_resp.sv ====
`default_nettype none

`include "pmp_defs.svh"

module pmp_access_resp (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    req_valid_i,
  input  logic [`PMP_PADDR_W-1:0] req_addr_i,
  input  logic                    access_fault_i,
  input  logic                    fault_clr_i,
  output logic                    resp_valid_o,
  output logic                    resp_err_o,
  output logic                    fault_valid_o,
  output logic [`PMP_PADDR_W-1:0] fault_addr_o
);

  logic resp_valid_q;
  logic resp_err_q;
  logic fault_valid_q;
  logic new_fault;
  logic capture;

  assign new_fault = req_valid_i && access_fault_i;
  // First fault, or a fault that arrives with the clear
  assign capture   = new_fault && (!fault_valid_q || fault_clr_i);

  // --------------------------------------------------
  // Response and fault flag
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q  <= 1'b0;
      resp_err_q    <= 1'b0;
      fault_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= req_valid_i;
      resp_err_q   <= new_fault;
      if (capture) begin
        fault_valid_q <= 1'b1;
      end else if (fault_clr_i) begin
        fault_valid_q <= 1'b0;
      end
    end
  end

  // Trap value, held until cleared
  always_ff @(posedge clk) begin
    if (capture) fault_addr_o <= req_addr_i;
  end

  assign resp_valid_o  = resp_valid_q;
  assign resp_err_o    = resp_err_q;
  assign fault_valid_o = fault_valid_q;

  a_err_has_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
    resp_err_o |-> resp_valid_o);
  a_resp_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    resp_valid_o |-> $past(req_valid_i));

endmodule

`default_nettype wire

// ==== hdl/pmp_top.sv ====
`default_nettype none

`include "pmp_defs.svh"

module pmp_top import pmp_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n_i,
  // CSR port
  input  logic                    csr_we_i,
  input  pmp_csr_sel_e            csr_sel_i,
  input  logic [3:0]              csr_idx_i,
  input  logic [`PMP_CSR_W-1:0]   csr_wdata_i,
  output logic [`PMP_CSR_W-1:0]   csr_rdata_o,
  // Access port
  input  logic                    req_valid_i,
  input  logic [`PMP_PADDR_W-1:0] req_addr_i,
  input  pmp_acc_e                req_type_i,
  input  priv_lvl_e               req_priv_i,
  input  logic                    fault_clr_i,
  output logic                    resp_valid_o,
  output logic                    resp_err_o,
  output logic                    fault_valid_o,
  output logic [`PMP_PADDR_W-1:0] fault_addr_o
);

  // CSR bank to checker
  logic [`PMP_NUM_REGIONS-1:0]                   cfg_read;
  logic [`PMP_NUM_REGIONS-1:0]                   cfg_write;
  logic [`PMP_NUM_REGIONS-1:0]                   cfg_exec;
  logic [`PMP_NUM_REGIONS-1:0]                   cfg_lock;
  pmp_mode_e [`PMP_NUM_REGIONS-1:0]              cfg_mode;
  logic [`PMP_NUM_REGIONS-1:0][`PMP_PADDR_W-1:0] region_addr;
  logic                                          mml;
  logic                                          mmwp;
  // Checker to response stage
  logic                                          access_fault;

  pmp_csr u_csr (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .csr_we_i      (csr_we_i),
    .csr_sel_i     (csr_sel_i),
    .csr_idx_i     (csr_idx_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_rdata_o   (csr_rdata_o),
    .cfg_read_o    (cfg_read),
    .cfg_write_o   (cfg_write),
    .cfg_exec_o    (cfg_exec),
    .cfg_lock_o    (cfg_lock),
    .cfg_mode_o    (cfg_mode),
    .region_addr_o (region_addr),
    .mml_o         (mml),
    .mmwp_o        (mmwp),
    // RLB only gates CSR writes inside the bank
    .rlb_o         ()
  );

  pmp_checker u_checker (
    .cfg_read_i     (cfg_read),
    .cfg_write_i    (cfg_write),
    .cfg_exec_i     (cfg_exec),
    .cfg_lock_i     (cfg_lock),
    .cfg_mode_i     (cfg_mode),
    .region_addr_i  (region_addr),
    .mml_i          (mml),
    .mmwp_i         (mmwp),
    .req_addr_i     (req_addr_i),
    .req_type_i     (req_type_i),
    .req_priv_i     (req_priv_i),
    .access_fault_o (access_fault)
  );

  pmp_access_resp u_resp (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_addr_i     (req_addr_i),
    .access_fault_i (access_fault),
    .fault_clr_i    (fault_clr_i),
    .resp_valid_o   (resp_valid_o),
    .resp_err_o     (resp_err_o),
    .fault_valid_o  (fault_valid_o),
    .fault_addr_o   (fault_addr_o)
  );

endmodule

`default_nettype wire

// ==== sim/pmp_tb.sv ====
`default_nettype none

`include "pmp_defs.svh"

module pmp_tb import pmp_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NR           = `PMP_NUM_REGIONS;
  localparam int RESP_TIMEOUT = 20;
  // MML encodings in LRWX order 0010 0011 1010 1011 1111 then unlocked RWX and locked R
  localparam logic [7:0] MML_ENC [7] = '{8'h12, 8'h16, 8'h92, 8'h96, 8'h97, 8'h17, 8'h91};

  logic                    clk;
  logic                    rst_n;
  logic                    csr_we;
  pmp_csr_sel_e            csr_sel;
  logic [3:0]              csr_idx;
  logic [`PMP_CSR_W-1:0]   csr_wdata;
  logic [`PMP_CSR_W-1:0]   csr_rdata;
  logic                    req_valid;
  logic [`PMP_PADDR_W-1:0] req_addr;
  pmp_acc_e                req_type;
  priv_lvl_e               req_priv;
  logic                    fault_clr;
  logic                    resp_valid;
  logic                    resp_err;
  logic                    fault_valid;
  logic [`PMP_PADDR_W-1:0] fault_addr;

  // Reference state updated on every CSR write
  logic [7:0]              m_cfg [NR];
  logic [31:0]             m_addr [NR];
  logic                    m_mml;
  logic                    m_mmwp;
  logic                    m_rlb;
  logic [31:0]             rng_state = 32'd53;
  int                      errors = 0;
  int                      timeouts = 0;

  pmp_top dut (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .csr_we_i      (csr_we),
    .csr_sel_i     (csr_sel),
    .csr_idx_i     (csr_idx),
    .csr_wdata_i   (csr_wdata),
    .csr_rdata_o   (csr_rdata),
    .req_valid_i   (req_valid),
    .req_addr_i    (req_addr),
    .req_type_i    (req_type),
    .req_priv_i    (req_priv),
    .fault_clr_i   (fault_clr),
    .resp_valid_o  (resp_valid),
    .resp_err_o    (resp_err),
    .fault_valid_o (fault_valid),
    .fault_addr_o  (fault_addr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic pmp_acc_e acc_from_int(int v);
    case (v % 3)
      0:       return PMP_ACC_READ;
      1:       return PMP_ACC_WRITE;
      default: return PMP_ACC_EXEC;
    endcase
  endfunction

  function automatic priv_lvl_e priv_from_int(int v);
    case (v % 3)
      0:       return PRIV_LVL_U;
      1:       return PRIV_LVL_S;
      default: return PRIV_LVL_M;
    endcase
  endfunction

  // Byte-level range test for one region
  function automatic logic region_hit(int r, logic [33:0] a);
    logic [63:0] aa;
    logic [63:0] lo;
    logic [63:0] hi;
    logic [63:0] sz;
    int          k;
    aa = {30'd0, a[33:2], 2'b00};
    hi = {30'd0, m_addr[r], 2'b00};
    lo = 64'd0;
    if (r > 0) lo = {30'd0, m_addr[r-1], 2'b00};
    // NAPOT size from the trailing ones of the address register
    k = 0;
    while (k < 32 && m_addr[r][k]) k++;
    sz = 64'd8 << k;
    case (m_cfg[r][4:3])
      2'b01:   return (aa >= lo) && (aa < hi);
      2'b10:   return aa == hi;
      2'b11:   return (aa & ~(sz - 64'd1)) == (hi & ~(sz - 64'd1));
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic model_fault(logic [33:0] a, pmp_acc_e t, priv_lvl_e p);
    logic       m;
    logic       rd;
    logic       wr;
    logic       ex;
    logic       perm;
    logic       ok;
    logic [3:0] lrwx;
    m  = (p == PRIV_LVL_M);
    rd = (t == PMP_ACC_READ);
    wr = (t == PMP_ACC_WRITE);
    ex = (t == PMP_ACC_EXEC);
    for (int r = 0; r < NR; r++) begin
      if (region_hit(r, a)) begin
        perm = (rd && m_cfg[r][0]) || (wr && m_cfg[r][1]) || (ex && m_cfg[r][2]);
        lrwx = {m_cfg[r][7], m_cfg[r][0], m_cfg[r][1], m_cfg[r][2]};
        if (m_mml) begin
          case (lrwx)
            4'b0010: ok = rd || (wr && m);
            4'b0011: ok = rd || wr;
            4'b1010: ok = ex;
            4'b1011: ok = ex || (rd && m);
            4'b1111: ok = rd;
            // Locked rules belong to M and unlocked ones to S and U
            default: ok = perm && (m_cfg[r][7] == m);
          endcase
          return !ok;
        end
        return m ? (m_cfg[r][7] && !perm) : !perm;
      end
    end
    // No region matched
    return m_mmwp || !m;
  endfunction

  function automatic logic [31:0] model_rdata(pmp_csr_sel_e sel, int idx);
    logic [31:0] v;
    v = 32'd0;
    if (sel == PMP_CSR_MSECCFG) begin
      v = {29'd0, m_rlb, m_mmwp, m_mml};
    end else if (idx < NR) begin
      v = (sel == PMP_CSR_CFG) ? {24'd0, m_cfg[idx]} : m_addr[idx];
    end
    return v;
  endfunction

  // --------------------------------------------------
  // Drivers and checks
  // --------------------------------------------------
  task automatic check_val(string name, logic [63:0] exp, logic [63:0] act);
    assert (act === exp) else begin
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    csr_we = 1'b0;
    req_valid = 1'b0;
    fault_clr = 1'b0;
    for (int r = 0; r < NR; r++) begin
      m_cfg[r]  = 8'd0;
      m_addr[r] = 32'd0;
    end
    m_mml  = 1'b0;
    m_mmwp = 1'b0;
    m_rlb  = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // One CSR write strobe mirrored with the lock rules
  task automatic csr_write(pmp_csr_sel_e sel, int idx, logic [31:0] wd);
    logic any_lock;
    logic tor_above;
    any_lock = 1'b0;
    for (int r = 0; r < NR; r++) any_lock = any_lock | m_cfg[r][7];
    if (sel == PMP_CSR_MSECCFG) begin
      m_mml  = m_mml | wd[0];
      m_mmwp = m_mmwp | wd[1];
      m_rlb  = wd[2] && (m_rlb || !any_lock);
    end else if (idx < NR) begin
      tor_above = 1'b0;
      if (idx + 1 < NR) begin
        tor_above = m_cfg[idx+1][7] && !m_rlb && (m_cfg[idx+1][4:3] == 2'b01);
      end
      if (sel == PMP_CSR_CFG && !(m_cfg[idx][7] && !m_rlb)) begin
        m_cfg[idx] = {wd[7], 2'b00, wd[4:0]};
      end
      if (sel == PMP_CSR_ADDR && !(m_cfg[idx][7] && !m_rlb) && !tor_above) begin
        m_addr[idx] = wd;
      end
    end
    @(negedge clk);
    csr_we    = 1'b1;
    csr_sel   = sel;
    csr_idx   = 4'(idx);
    csr_wdata = wd;
    @(negedge clk);
    csr_we = 1'b0;
  endtask

  task automatic check_csr(string name, pmp_csr_sel_e sel, int idx);
    @(negedge clk);
    csr_sel = sel;
    csr_idx = 4'(idx);
    #10;
    check_val(name, 64'(model_rdata(sel, idx)), 64'(csr_rdata));
  endtask

  // Request strobe with an optional fault clear in the same cycle
  task automatic run_access(string name, logic [33:0] addr, pmp_acc_e t, priv_lvl_e p,
                            logic clr);
    logic exp_err;
    int   waited;
    exp_err = model_fault(addr, t, p);
    @(negedge clk);
    req_valid = 1'b1;
    req_addr  = addr;
    req_type  = t;
    req_priv  = p;
    fault_clr = clr;
    waited = 0;
    do begin
      @(negedge clk);
      req_valid = 1'b0;
      fault_clr = 1'b0;
      waited++;
    end while (!resp_valid && waited < RESP_TIMEOUT);
    if (!resp_valid) begin
      $display("No response to request %s within %0d cycles", name, RESP_TIMEOUT);
      timeouts++;
    end else begin
      check_val({name, " latency"}, 64'd1, 64'(waited));
      check_val(name, 64'(exp_err), 64'(resp_err));
    end
  endtask

  task automatic clear_fault();
    @(negedge clk);
    fault_clr = 1'b1;
    @(negedge clk);
    fault_clr = 1'b0;
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic test_reset_state();
    logic [33:0] addr;
    check_val("reset resp_valid", 64'd0, 64'(resp_valid));
    check_val("reset resp_err", 64'd0, 64'(resp_err));
    check_val("reset fault_valid", 64'd0, 64'(fault_valid));
    for (int i = 0; i < 4; i++) begin
      addr = {next_rand(), 2'b00};
      run_access("reset M read", addr, PMP_ACC_READ, PRIV_LVL_M, 1'b0);
      run_access("reset S read", addr, PMP_ACC_READ, PRIV_LVL_S, 1'b0);
      run_access("reset U exec", addr, PMP_ACC_EXEC, PRIV_LVL_U, 1'b0);
    end
  endtask

  task automatic test_region_match();
    logic [31:0] r;
    logic [31:0] s;
    logic [33:0] addr;
    // NA4 at 0x1000 with R only inside NAPOT region 1
    csr_write(PMP_CSR_ADDR, 0, 32'h0000_0400);
    csr_write(PMP_CSR_CFG, 0, 32'h11);
    csr_write(PMP_CSR_ADDR, 1, 32'h0000_05FF);
    csr_write(PMP_CSR_CFG, 1, 32'h1B);
    // TOR 0x2000 to 0x6000 with R and X
    csr_write(PMP_CSR_ADDR, 2, 32'h0000_0800);
    csr_write(PMP_CSR_ADDR, 3, 32'h0000_1800);
    csr_write(PMP_CSR_CFG, 3, 32'h0D);
    // NAPOT 64 KiB at 0 with RWX below all the others
    csr_write(PMP_CSR_ADDR, 4, 32'h0000_1FFF);
    csr_write(PMP_CSR_CFG, 4, 32'h1F);
    run_access("region0 priority", 34'h1000, PMP_ACC_WRITE, PRIV_LVL_U, 1'b0);
    run_access("region1 write", 34'h1800, PMP_ACC_WRITE, PRIV_LVL_U, 1'b0);
    run_access("tor exec", 34'h3000, PMP_ACC_EXEC, PRIV_LVL_S, 1'b0);
    repeat (64) begin
      r = next_rand();
      s = next_rand();
      // Half of the addresses land in the programmed window
      addr = s[0] ? {18'd0, r[15:0]} : {s[2:1], r};
      run_access($sformatf("random %0h", addr), addr, acc_from_int(int'(s[15:8])),
                 priv_from_int(int'(s[23:16])), 1'b0);
    end
  endtask

  task automatic test_lock_rules();
    csr_write(PMP_CSR_ADDR, 5, 32'h0000_8000);
    csr_write(PMP_CSR_ADDR, 6, 32'h0000_C000);
    csr_write(PMP_CSR_CFG, 6, 32'h89);
    run_access("lock M read", 34'h24000, PMP_ACC_READ, PRIV_LVL_M, 1'b0);
    run_access("lock M write", 34'h24000, PMP_ACC_WRITE, PRIV_LVL_M, 1'b0);
    run_access("lock M exec", 34'h24000, PMP_ACC_EXEC, PRIV_LVL_M, 1'b0);
    run_access("lock M outside", 34'h50000, PMP_ACC_WRITE, PRIV_LVL_M, 1'b0);
    csr_write(PMP_CSR_CFG, 6, 32'h0F);
    check_csr("locked cfg", PMP_CSR_CFG, 6);
    check_val("locked cfg value", 64'(32'h89), 64'(csr_rdata));
    csr_write(PMP_CSR_ADDR, 6, 32'h1234);
    check_csr("locked addr", PMP_CSR_ADDR, 6);
    csr_write(PMP_CSR_ADDR, 5, 32'h1234);
    check_csr("addr below tor", PMP_CSR_ADDR, 5);
    check_val("addr below tor value", 64'(32'h8000), 64'(csr_rdata));
    // RLB refuses to set once an entry is locked
    csr_write(PMP_CSR_MSECCFG, 0, 32'h4);
    check_csr("rlb after lock", PMP_CSR_MSECCFG, 0);
    csr_write(PMP_CSR_CFG, 9, 32'h1F);
    check_csr("index out of range", PMP_CSR_CFG, 9);
    // Dropped upper index bits would land on this entry
    check_csr("index out of range alias", PMP_CSR_CFG, 9 % NR);
  endtask

  task automatic test_rlb();
    csr_write(PMP_CSR_MSECCFG, 0, 32'h4);
    check_csr("rlb set", PMP_CSR_MSECCFG, 0);
    csr_write(PMP_CSR_ADDR, 5, 32'h0000_8000);
    csr_write(PMP_CSR_ADDR, 6, 32'h0000_C000);
    csr_write(PMP_CSR_CFG, 6, 32'h89);
    csr_write(PMP_CSR_CFG, 6, 32'h8B);
    check_csr("rlb cfg", PMP_CSR_CFG, 6);
    check_val("rlb cfg value", 64'(32'h8B), 64'(csr_rdata));
    csr_write(PMP_CSR_ADDR, 6, 32'h0000_D000);
    check_csr("rlb addr", PMP_CSR_ADDR, 6);
    csr_write(PMP_CSR_ADDR, 5, 32'h0000_9000);
    check_csr("rlb addr below tor", PMP_CSR_ADDR, 5);
    run_access("rlb M write", 34'h28000, PMP_ACC_WRITE, PRIV_LVL_M, 1'b0);
    // Clearing RLB brings the lock back
    csr_write(PMP_CSR_MSECCFG, 0, 32'h0);
    check_csr("rlb clear", PMP_CSR_MSECCFG, 0);
    csr_write(PMP_CSR_CFG, 6, 32'h0F);
    check_csr("relocked cfg", PMP_CSR_CFG, 6);
  endtask

  task automatic test_mml();
    logic [33:0] addr;
    // One NA4 entry per encoding at 0x100 steps
    for (int r = 0; r < 7; r++) begin
      csr_write(PMP_CSR_ADDR, r, 32'((r + 1) * 64));
      csr_write(PMP_CSR_CFG, r, {24'd0, MML_ENC[r]});
    end
    csr_write(PMP_CSR_MSECCFG, 0, 32'h1);
    check_csr("mml set", PMP_CSR_MSECCFG, 0);
    for (int r = 0; r < 7; r++) begin
      addr = 34'((r + 1) * 256);
      for (int t = 0; t < 3; t++) begin
        run_access($sformatf("mml r%0d t%0d M", r, t), addr, acc_from_int(t),
                   PRIV_LVL_M, 1'b0);
        run_access($sformatf("mml r%0d t%0d U", r, t), addr, acc_from_int(t),
                   PRIV_LVL_U, 1'b0);
      end
    end
  endtask

  task automatic test_mmwp();
    run_access("unmatched M before mmwp", 34'h2_0000_0000, PMP_ACC_READ, PRIV_LVL_M, 1'b0);
    csr_write(PMP_CSR_MSECCFG, 0, 32'h2);
    run_access("unmatched M with mmwp", 34'h2_0000_0000, PMP_ACC_READ, PRIV_LVL_M, 1'b0);
    // Clear attempt leaves MML and MMWP set
    csr_write(PMP_CSR_MSECCFG, 0, 32'h0);
    check_csr("msec sticky", PMP_CSR_MSECCFG, 0);
    check_val("msec sticky value", 64'(32'h3), 64'(csr_rdata));
  endtask

  task automatic test_fault_capture();
    run_access("fault first", 34'h1230, PMP_ACC_READ, PRIV_LVL_U, 1'b0);
    run_access("fault second", 34'h4560, PMP_ACC_WRITE, PRIV_LVL_U, 1'b0);
    check_val("fault valid", 64'd1, 64'(fault_valid));
    check_val("fault addr first", 64'(34'h1230), 64'(fault_addr));
    clear_fault();
    check_val("fault cleared", 64'd0, 64'(fault_valid));
    run_access("fault after clear", 34'h7890, PMP_ACC_EXEC, PRIV_LVL_S, 1'b0);
    check_val("fault valid again", 64'd1, 64'(fault_valid));
    check_val("fault addr after clear", 64'(34'h7890), 64'(fault_addr));
    // New fault wins over a clear in the same cycle
    run_access("fault with clear", 34'hABC0, PMP_ACC_READ, PRIV_LVL_U, 1'b1);
    check_val("fault valid with clear", 64'd1, 64'(fault_valid));
    check_val("fault addr with clear", 64'(34'hABC0), 64'(fault_addr));
  endtask

  initial begin
    rst_n     = 1'b0;
    csr_we    = 1'b0;
    csr_sel   = PMP_CSR_CFG;
    csr_idx   = 4'd0;
    csr_wdata = 32'd0;
    req_valid = 1'b0;
    req_addr  = 34'd0;
    req_type  = PMP_ACC_READ;
    req_priv  = PRIV_LVL_M;
    fault_clr = 1'b0;
    apply_reset();
    test_reset_state();
    test_region_match();
    apply_reset();
    test_lock_rules();
    apply_reset();
    test_rlb();
    apply_reset();
    test_mml();
    test_mmwp();
    apply_reset();
    test_fault_capture();
    $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hdl
hdl/pmp_pkg.sv
hdl/pmp_csr.sv
hdl/pmp_checker.sv
hdl/pmp_access_resp.sv
hdl/pmp_top.sv
sim/pmp_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the PMP testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps --top-module pmp_tb \
  -f filelist.f -o pmp_sim 2>&1 | tee build.log &&
  ./obj_dir/pmp_sim 2>&1 | tee sim.log &&
  ! grep -q "Simulation finished: FAIL" sim.log ||
  { echo "Simulation run failed"; exit 1; }

echo "Simulation run passed"
